// File: filelist.f
+incdir+include
src/uart_pkg.sv
src/uart_bit_timer.sv
src/uart_tx.sv
src/uart_rx.sv
src/uart_top.sv
dv/uart_clk_gen.sv
dv/uart_tb.sv

// File: Makefile
VERILATOR ?= verilator
TOP       := uart_tb
RTL_TOP   := uart_top
FILELIST  := filelist.f
OBJ_DIR   := obj_dir
VFLAGS    := --binary --timing --assert -j 0 --top-module $(TOP) -Mdir $(OBJ_DIR)
SIM       := $(OBJ_DIR)/V$(TOP)

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  help   list the targets"
	@echo "  test   build $(TOP) around $(RTL_TOP) with Verilator and run it"
	@echo "  clean  remove the build directory"

# a $$fatal in the testbench gives a nonzero exit, so make fails too
test:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST)
	./$(SIM)

clean:
	rm -rf $(OBJ_DIR)

// File: dv/uart_tb.sv
`timescale 1ns/10ps
`default_nettype none

`include "uart_settings.svh"

module uart_tb;
	import uart_pkg::*;

	localparam int          CPB          = `UART_CLOCKS_PER_BIT;
	localparam int          FRAME_BITS   = 11;   // start, data, parity, stop
	localparam int          RESET_CYCLES = 16;
	localparam int          LOOP_FRAMES  = 40;   // random loopback bytes
	localparam int          NUM_FRAMES   = LOOP_FRAMES + 1 + 3;   // plus busy test and line frames
	localparam int          TIMEOUT_CYCLES = (NUM_FRAMES * FRAME_BITS * CPB + RESET_CYCLES) * 3 / 2;
	localparam logic [31:0] LFSR_SEED    = 32'h2de6;
	localparam logic [31:0] LFSR_TAPS    = 32'h80200003;   // x^32 + x^22 + x^2 + x + 1

	logic     tx_clk;
	logic     reset_tx;
	logic     tx_start;
	data_t    tx_data;
	logic     tx_busy;
	logic     tx_serial;
	logic     rx_serial;
	logic     rx_valid;
	rx_word_t rx_word;

	logic        loop_sel;     // 1 loops tx back, 0 uses bang_line
	logic        bang_line;    // line driven by the testbench
	logic [31:0] lfsr_state;
	int          cycle_cnt = 0;

	// expected receive results, written at send time
	rx_word_t   exp_mem [0:63];
	logic [5:0] wr_ptr;
	logic [5:0] rd_ptr;
	rx_word_t   exp_head;
	data_t      exp_data;
	logic       exp_err;
	data_t      rx_data;
	logic       rx_err;

	// transmit reference model
	logic                  model_busy;
	int                    model_phase;   // cycle within the bit
	logic [3:0]            model_bit;     // bit on the line
	logic [FRAME_BITS-1:0] model_frame;   // start bit in the lsb

	assign rx_serial = loop_sel ? tx_serial : bang_line;
	assign exp_head  = exp_mem[rd_ptr];
	assign exp_data  = exp_head.data;
	assign exp_err   = exp_head.error;
	assign rx_data   = rx_word.data;
	assign rx_err    = rx_word.error;

	uart_clk_gen #(
		.PERIOD_NS    (4.0),
		.RESET_CYCLES (RESET_CYCLES)
	) u_clk_gen (
		.o_tx_clk   (tx_clk),
		.o_reset_tx (reset_tx)
	);

	uart_top u_uart_top (
		.tx_clk      (tx_clk),
		.reset_tx    (reset_tx),
		.i_tx_start  (tx_start),
		.i_tx_data   (tx_data),
		.o_tx_busy   (tx_busy),
		.o_tx_serial (tx_serial),
		.i_rx_serial (rx_serial),
		.o_rx_valid  (rx_valid),
		.o_rx_word   (rx_word)
	);

	task automatic report_fail(input string msg);
		$display("%s", msg);
		$display("Some tests failed");
		$fatal(1);
	endtask

	// galois step, shifts right and folds the taps in on a one
	function automatic logic [31:0] lfsr_next(input logic [31:0] s);
		if (s[0]) begin
			return (s >> 1) ^ LFSR_TAPS;
		end
		return s >> 1;
	endfunction

	// parity bit that makes the ones count even, or odd when selected
	function automatic logic frame_parity(input data_t d);
		data_t v;
		int    ones;
		v    = d;
		ones = 0;
		repeat (`UART_DATA_BITS) begin
			ones = ones + int'(v[0]);
			v    = v >> 1;
		end
		if (`UART_PARITY_ODD != 0) begin
			return (ones % 2) == 0;
		end
		return (ones % 2) == 1;
	endfunction

	task automatic random_byte(output data_t b);
		b = '0;
		repeat (`UART_DATA_BITS) begin
			lfsr_state = lfsr_next(lfsr_state);   // one step per bit
			b = {lfsr_state[0], b[`UART_DATA_BITS-1:1]};
		end
	endtask

	task automatic send_byte(input data_t b);
		while (tx_busy) begin
			@(posedge tx_clk);
		end
		tx_start        <= 1'b1;
		tx_data         <= b;
		exp_mem[wr_ptr] <= '{data: b, error: 1'b0};
		wr_ptr          <= wr_ptr + 6'd1;
		@(posedge tx_clk);
		tx_start <= 1'b0;
		@(posedge tx_clk);
	endtask

	// drives one frame on bang_line, then two idle bit periods
	task automatic bang_frame(input data_t d, input logic flip_parity, input logic stop_bit);
		logic [FRAME_BITS-1:0] frame;
		frame = {stop_bit, frame_parity(d) ^ flip_parity, d, 1'b0};
		exp_mem[wr_ptr] <= '{data: d, error: flip_parity | ~stop_bit};
		wr_ptr          <= wr_ptr + 6'd1;
		repeat (FRAME_BITS) begin
			bang_line <= frame[0];
			frame     = frame >> 1;
			repeat (CPB) @(posedge tx_clk);
		end
		bang_line <= 1'b1;   // back to idle, gives the re-arm edge room
		repeat (2 * CPB) @(posedge tx_clk);
	endtask

	task automatic wait_drain();
		while (rd_ptr != wr_ptr) begin
			@(posedge tx_clk);
		end
	endtask

	always_ff @(posedge tx_clk) begin
		if (reset_tx) begin
			model_busy  <= 1'b0;
			model_phase <= 0;
			model_bit   <= '0;
			model_frame <= '1;
		end else if (tx_start && !model_busy) begin
			model_busy  <= 1'b1;
			model_phase <= 0;
			model_bit   <= '0;
			model_frame <= {1'b1, frame_parity(tx_data), tx_data, 1'b0};
		end else if (model_busy) begin
			if (model_phase == CPB - 1) begin
				model_phase <= 0;
				if (model_bit == 4'(FRAME_BITS - 1)) begin
					model_busy <= 1'b0;   // stop bit done
				end else begin
					model_bit <= model_bit + 4'd1;
				end
			end else begin
				model_phase <= model_phase + 1;
			end
		end
	end

	always_ff @(posedge tx_clk) begin
		if (reset_tx) begin
			rd_ptr <= '0;
		end else if (rx_valid) begin
			rd_ptr <= rd_ptr + 6'd1;   // each pulse consumes one entry
		end
	end

	always @(posedge tx_clk) begin
		cycle_cnt <= cycle_cnt + 1;
		if (cycle_cnt >= TIMEOUT_CYCLES) begin
			report_fail($sformatf("Timeout: run still going after %0d cycles", cycle_cnt));
		end
	end

	a_rst_busy: assert property (@(posedge tx_clk) reset_tx |=> !tx_busy)
		else report_fail($sformatf("Mismatch at %0t: o_tx_busy got %b, expected 0",
			$time, $sampled(tx_busy)));
	a_rst_serial: assert property (@(posedge tx_clk) reset_tx |=> tx_serial)
		else report_fail($sformatf("Mismatch at %0t: o_tx_serial got %b, expected 1",
			$time, $sampled(tx_serial)));
	a_rst_valid: assert property (@(posedge tx_clk) reset_tx |=> !rx_valid)
		else report_fail($sformatf("Mismatch at %0t: o_rx_valid got %b, expected 0",
			$time, $sampled(rx_valid)));

	// busy length and ignored strobes both show up here
	a_busy: assert property (@(posedge tx_clk) disable iff (reset_tx)
		tx_busy == model_busy)
		else report_fail($sformatf("Mismatch at %0t: o_tx_busy got %b, expected %b",
			$time, $sampled(tx_busy), $sampled(model_busy)));
	a_frame_bit: assert property (@(posedge tx_clk) disable iff (reset_tx)
		(model_busy && model_phase == CPB / 2) |-> tx_serial == model_frame[model_bit])
		else report_fail($sformatf("Mismatch at %0t: o_tx_serial got %b, expected %b",
			$time, $sampled(tx_serial), $sampled(model_frame[model_bit])));

	a_rx_expected: assert property (@(posedge tx_clk) disable iff (reset_tx)
		rx_valid |-> rd_ptr != wr_ptr)
		else report_fail($sformatf("Receiver reported a byte at %0t with none expected",
			$time));
	a_rx_data: assert property (@(posedge tx_clk) disable iff (reset_tx)
		(rx_valid && rd_ptr != wr_ptr) |-> rx_data == exp_data)
		else report_fail($sformatf("Mismatch at %0t: o_rx_word.data got %h, expected %h",
			$time, $sampled(rx_data), $sampled(exp_data)));
	a_rx_error: assert property (@(posedge tx_clk) disable iff (reset_tx)
		(rx_valid && rd_ptr != wr_ptr) |-> rx_err == exp_err)
		else report_fail($sformatf("Mismatch at %0t: o_rx_word.error got %b, expected %b",
			$time, $sampled(rx_err), $sampled(exp_err)));

	initial begin
		data_t b;
		data_t first;
		tx_start   = 1'b0;
		tx_data    = '0;
		loop_sel   = 1'b1;
		bang_line  = 1'b1;
		wr_ptr     = '0;
		lfsr_state = LFSR_SEED;

		@(posedge tx_clk);   // reset is up by the first edge
		while (reset_tx) begin
			@(posedge tx_clk);
		end
		repeat (4) @(posedge tx_clk);

		// loopback with random bytes, back to back
		repeat (LOOP_FRAMES) begin
			random_byte(b);
			send_byte(b);
		end

		// second strobe lands mid frame and must be dropped
		random_byte(first);
		send_byte(first);
		repeat (3 * CPB) @(posedge tx_clk);
		tx_start <= 1'b1;
		tx_data  <= first ^ 8'hff;
		@(posedge tx_clk);
		tx_start <= 1'b0;
		wait_drain();
		while (tx_busy) begin
			@(posedge tx_clk);
		end

		// hand the line to the testbench, both sources idle high
		loop_sel <= 1'b0;
		repeat (2 * CPB) @(posedge tx_clk);
		random_byte(b);
		bang_frame(b, 1'b1, 1'b1);   // bad parity
		random_byte(b);
		bang_frame(b, 1'b0, 1'b0);   // framing error
		random_byte(b);
		bang_frame(b, 1'b0, 1'b1);   // clean frame after errors
		wait_drain();

		// quiet window catches any stray valid pulse
		repeat (FRAME_BITS * CPB) @(posedge tx_clk);
		$display("All tests passed");
		$finish;
	end

endmodule

`default_nettype wire

// File: dv/uart_clk_gen.sv
`timescale 1ns/10ps
`default_nettype none

module uart_clk_gen #(
	parameter real PERIOD_NS    = 4.0,   // tx_clk period
	parameter int  RESET_CYCLES = 16     // reset length in clock cycles
) (
	output logic o_tx_clk,
	output logic o_reset_tx
);

	initial begin
		o_tx_clk = 1'b0;
		forever #(PERIOD_NS / 2.0) o_tx_clk = ~o_tx_clk;   // free running
	end

	initial begin
		o_reset_tx = 1'b1;   // asserted from time zero
		repeat (RESET_CYCLES) @(posedge o_tx_clk);
		o_reset_tx <= 1'b0;   // released on a rising edge
	end

endmodule

`default_nettype wire

// File: src/uart_top.sv
`timescale 1ns/10ps
`default_nettype none

module uart_top (
	input  logic               tx_clk,
	input  logic               reset_tx,
	input  logic               i_tx_start,    // send request strobe
	input  uart_pkg::data_t    i_tx_data,     // byte to send
	output logic               o_tx_busy,     // transmitter in use
	output logic               o_tx_serial,   // serial out
	input  logic               i_rx_serial,   // serial in, may be looped from o_tx_serial
	output logic               o_rx_valid,    // received byte strobe
	output uart_pkg::rx_word_t o_rx_word      // received byte and error flag
);
	import uart_pkg::*;

	// transmit side
	uart_tx u_uart_tx (
		.tx_clk      (tx_clk),
		.reset_tx    (reset_tx),
		.i_tx_start  (i_tx_start),
		.i_tx_data   (i_tx_data),
		.o_tx_busy   (o_tx_busy),
		.o_tx_serial (o_tx_serial)
	);

	// receive side, same clock and reset
	uart_rx u_uart_rx (
		.tx_clk      (tx_clk),
		.reset_tx    (reset_tx),
		.i_rx_serial (i_rx_serial),
		.o_rx_valid  (o_rx_valid),
		.o_rx_word   (o_rx_word)
	);

endmodule

`default_nettype wire

// File: src/uart_rx.sv
`timescale 1ns/10ps
`default_nettype none

`include "uart_settings.svh"

module uart_rx (
	input  logic               tx_clk,
	input  logic               reset_tx,
	input  logic               i_rx_serial,   // async line in
	output logic               o_rx_valid,    // one-cycle result strobe
	output uart_pkg::rx_word_t o_rx_word      // held until the next strobe
);
	import uart_pkg::*;

	localparam int       SYNC_W    = `UART_SYNC_STAGES;
	localparam bit_idx_t LAST_DATA = bit_idx_t'(`UART_DATA_BITS - 1);

	logic [SYNC_W-1:0] sync_q;          // synchronizer chain
	logic              rx_line;         // synchronized line
	logic              rx_line_d;       // previous rx_line
	logic              start_edge;      // high to low on rx_line
	logic              timer_restart;   // arm the half-period timer
	logic              timer_run;
	logic              bit_tick;        // middle of a bit
	rx_state_t         state;
	bit_idx_t          bit_idx;         // data bit being sampled
	data_t             rx_shift;        // data comes in from the top
	logic              parity_err;      // parity bit did not match

	always_ff @(posedge tx_clk) begin
		if (reset_tx) begin
			sync_q    <= '1;   // line idles high
			rx_line_d <= 1'b1;
		end else begin
			sync_q    <= {sync_q[SYNC_W-2:0], i_rx_serial};
			rx_line_d <= rx_line;
		end
	end

	assign rx_line    = sync_q[SYNC_W-1];
	assign start_edge = rx_line_d & ~rx_line;

	// only a fresh falling edge re-arms, a held low line does not
	assign timer_restart = (state == RX_IDLE) & start_edge;
	assign timer_run     = (state != RX_IDLE);

	// first tick at half a period lands in the middle of the start bit
	uart_bit_timer #(
		.FIRST_TICK (`UART_CLOCKS_PER_BIT / 2 - 1)
	) u_bit_timer (
		.tx_clk    (tx_clk),
		.reset_tx  (reset_tx),
		.i_restart (timer_restart),
		.i_run     (timer_run),
		.o_tick    (bit_tick)
	);

	always_ff @(posedge tx_clk) begin
		if (reset_tx) begin
			state      <= RX_IDLE;
			bit_idx    <= '0;
			o_rx_valid <= 1'b0;
			o_rx_word  <= '0;
		end else begin
			o_rx_valid <= 1'b0;   // pulse by default
			case (state)
				RX_IDLE: begin
					if (start_edge) begin
						state <= RX_START;
					end
				end
				RX_START: begin
					if (bit_tick) begin
						if (rx_line) begin
							state <= RX_IDLE;   // glitch, not a start bit
						end else begin
							state   <= RX_DATA;
							bit_idx <= '0;
						end
					end
				end
				RX_DATA: begin
					if (bit_tick) begin
						bit_idx <= bit_idx + 1'b1;
						if (bit_idx == LAST_DATA) begin
							state <= RX_PARITY;
						end
					end
				end
				RX_PARITY: begin
					if (bit_tick) begin
						state <= RX_STOP;
					end
				end
				RX_STOP: begin
					if (bit_tick) begin
						state      <= RX_IDLE;
						o_rx_valid <= 1'b1;
						o_rx_word  <= '{
							data:  rx_shift,
							error: parity_err | ~rx_line   // bad parity or framing
						};
					end
				end
				default: begin
					state <= RX_IDLE;
				end
			endcase
		end
	end

	// payload path
	always_ff @(posedge tx_clk) begin
		if (bit_tick) begin
			if (state == RX_DATA) begin
				rx_shift <= {rx_line, rx_shift[`UART_DATA_BITS-1:1]};   // lsb first
			end
			if (state == RX_PARITY) begin
				parity_err <= rx_line ^ (^rx_shift) ^ 1'(`UART_PARITY_ODD);
			end
		end
	end

	// a result is never reported twice
	a_valid_pulse: assert property (@(posedge tx_clk) disable iff (reset_tx)
		o_rx_valid |=> !o_rx_valid)
		else $error("rx valid held for more than one cycle");

endmodule

`default_nettype wire

// File: src/uart_tx.sv
`timescale 1ns/10ps
`default_nettype none

`include "uart_settings.svh"

module uart_tx (
	input  logic            tx_clk,
	input  logic            reset_tx,
	input  logic            i_tx_start,    // one-cycle request
	input  uart_pkg::data_t i_tx_data,     // taken together with the strobe
	output logic            o_tx_busy,     // frame in flight
	output logic            o_tx_serial    // line out, idles high
);
	import uart_pkg::*;

	localparam int FRAME_BITS = $bits(tx_frame_t);   // start, data, parity, stop
	localparam int BIT_CNT_W  = $clog2(FRAME_BITS);
	localparam logic [BIT_CNT_W-1:0] LAST_BIT = BIT_CNT_W'(FRAME_BITS - 1);

	tx_frame_t            tx_frame;    // shifts toward the line
	logic [BIT_CNT_W-1:0] bit_cnt;     // finished bit periods
	logic                 tx_accept;   // strobe taken at this edge
	logic                 tx_parity;   // parity of the incoming byte
	logic                 bit_tick;    // current bit period is over
	logic                 last_bit;    // stop bit is on the line

	// a strobe while busy is dropped
	assign tx_accept = i_tx_start & ~o_tx_busy;

	// even parity is the xor of the data, odd flips it
	assign tx_parity = (^i_tx_data) ^ 1'(`UART_PARITY_ODD);

	assign last_bit = (bit_cnt == LAST_BIT);

	// line comes straight from a flop
	assign o_tx_serial = tx_frame.start;

	// full period so the first tick ends the start bit
	uart_bit_timer #(
		.FIRST_TICK (`UART_CLOCKS_PER_BIT - 1)
	) u_bit_timer (
		.tx_clk    (tx_clk),
		.reset_tx  (reset_tx),
		.i_restart (tx_accept),
		.i_run     (o_tx_busy),
		.o_tick    (bit_tick)
	);

	always_ff @(posedge tx_clk) begin
		if (reset_tx) begin
			o_tx_busy <= 1'b0;
		end else if (tx_accept) begin
			o_tx_busy <= 1'b1;   // same edge as start bit
		end else if (bit_tick && last_bit) begin
			o_tx_busy <= 1'b0;   // falls as the stop bit ends
		end
	end

	always_ff @(posedge tx_clk) begin
		if (reset_tx) begin
			bit_cnt <= '0;
		end else if (tx_accept) begin
			bit_cnt <= '0;
		end else if (bit_tick) begin
			if (last_bit) begin
				bit_cnt <= '0;
			end else begin
				bit_cnt <= bit_cnt + 1'b1;
			end
		end
	end

	// frame register doubles as the line driver, so it idles at all ones
	always_ff @(posedge tx_clk) begin
		if (reset_tx) begin
			tx_frame <= '1;
		end else if (tx_accept) begin
			tx_frame <= '{
				stop:   1'b1,
				parity: tx_parity,
				data:   i_tx_data,
				start:  1'b0
			};
		end else if (bit_tick) begin
			tx_frame <= {1'b1, tx_frame[FRAME_BITS-1:1]};   // ones fill in behind
		end
	end

	// line must sit at the idle level between frames
	a_idle_high: assert property (@(posedge tx_clk) disable iff (reset_tx)
		!o_tx_busy |-> o_tx_serial)
		else $error("tx line low while not busy");

endmodule

`default_nettype wire

// File: src/uart_bit_timer.sv
`timescale 1ns/10ps
`default_nettype none

`include "uart_settings.svh"

module uart_bit_timer #(
	parameter int FIRST_TICK = `UART_CLOCKS_PER_BIT - 1   // count at which ticks come
) (
	input  logic tx_clk,
	input  logic reset_tx,
	input  logic i_restart,   // start over from zero
	input  logic i_run,       // count enable
	output logic o_tick       // one pulse per bit period
);
	import uart_pkg::*;

	localparam baud_cnt_t LAST_CNT = baud_cnt_t'(`UART_CLOCKS_PER_BIT - 1);
	localparam baud_cnt_t TICK_CNT = baud_cnt_t'(FIRST_TICK);

	baud_cnt_t baud_cnt;   // position inside the bit period

	always_ff @(posedge tx_clk) begin
		if (reset_tx) begin
			baud_cnt <= '0;
		end else if (i_restart) begin
			baud_cnt <= '0;   // restart wins over run
		end else if (i_run) begin
			if (baud_cnt == LAST_CNT) begin
				baud_cnt <= '0;   // wrap once per period
			end else begin
				baud_cnt <= baud_cnt + 1'b1;
			end
		end
	end

	// same phase every period, so later ticks are a full period apart
	assign o_tick = i_run & ~i_restart & (baud_cnt == TICK_CNT);

	a_cnt_range: assert property (@(posedge tx_clk) disable iff (reset_tx)
		int'(baud_cnt) < `UART_CLOCKS_PER_BIT)
		else $error("bit timer count left its period");

endmodule

`default_nettype wire

// File: src/uart_pkg.sv
`default_nettype none

`include "uart_settings.svh"

package uart_pkg;

	typedef logic [`UART_DATA_BITS-1:0] data_t;                 // one payload byte
	typedef logic [$clog2(`UART_DATA_BITS)-1:0] bit_idx_t;      // data bit position
	typedef logic [$clog2(`UART_CLOCKS_PER_BIT)-1:0] baud_cnt_t; // cycle within a bit

	// transmit shift register, start bit sits in the LSB
	typedef struct packed {
		logic  stop;    // always 1
		logic  parity;  // even or odd over data
		data_t data;    // sent LSB first
		logic  start;   // always 0
	} tx_frame_t;

	// what the receiver hands out
	typedef struct packed {
		data_t data;    // received byte
		logic  error;   // parity mismatch or low stop bit
	} rx_word_t;

	typedef enum logic [2:0] {
		RX_IDLE,        // waiting for a falling edge
		RX_START,       // recheck start bit at mid point
		RX_DATA,        // collecting data bits
		RX_PARITY,      // parity bit sample
		RX_STOP         // stop bit sample, result out
	} rx_state_t;

endpackage

`default_nettype wire

// File: include/uart_settings.svh
`ifndef UART_SETTINGS_SVH
`define UART_SETTINGS_SVH

// data bits in one frame
`define UART_DATA_BITS 8

// tx_clk cycles per serial bit
`define UART_CLOCKS_PER_BIT 8

// flops in the receive line synchronizer
`define UART_SYNC_STAGES 3

// parity sense for both directions
// 0 gives even parity and 1 gives odd parity
`define UART_PARITY_ODD 0

`endif
